// File: run.sh
#!/usr/bin/env bash
# builds the palette testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps --top-module tb_lcd_palette \
	-f tb.f -Mdir obj_dir -o sim_tb; then
	echo "verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/sim_tb); then
	echo "$output"
	echo "simulation exited with an error"
	exit 1
fi
echo "$output"

if grep -qx "TEST PASSED" <<< "$output"; then
	exit 0
fi
echo "pass line not found in the simulation output"
exit 1

// File: tb.f
verilog/ppu_pkg.sv
verilog/cpu_io_decode.sv
verilog/palettes.sv
verilog/pixel_mixer.sv
verilog/shade_lookup.sv
verilog/lcd_palette_top.sv
verification/tb_lcd_palette.sv

// File: verification/tb_lcd_palette.sv
`timescale 1ns/1ps

module tb_lcd_palette
	import ppu_pkg::*;
	();

	localparam addr_t BASE = ADDR_BGP_DEFAULT;
	localparam int TIMEOUT = 20;

	logic        clk;
	logic        reset;
	addr_t       cpu_addr;
	cpu_data_t   cpu_wdata;
	logic        cpu_rd2;
	logic        cpu_wr2;
	cpu_data_t   cpu_rdata;
	logic        cpu_rdata_valid;
	logic        pix_valid;
	color_idx_t  bg_color;
	color_idx_t  obj_color;
	logic        obj_pal1;
	logic        obj_behind_bg;
	logic        shade_valid;
	shade_t      shade;

	// testbench copy of bgp, obp0 and obp1.
	palette_t    model_pal [3] = '{default: '0};
	shade_t      exp_q [$];
	logic [1:0]  valid_hist = '0;
	int          value_errors = 0;
	int          other_errors = 0;
	logic [31:0] lfsr = 32'hd2733525;

	lcd_palette_top #(.PAL_BASE(BASE)) uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_data(input string name, input cpu_data_t got, input cpu_data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_shade(input string name, input shade_t got, input shade_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
			value_errors++;
		end
	endtask

	// a nonzero sprite color shows unless it is behind a nonzero background.
	function automatic shade_t model_shade(input color_idx_t bg, input color_idx_t obj,
			input logic pal1, input logic behind);
		if (obj != 2'd0 && (!behind || bg == 2'd0)) begin
			return shade_t'(model_pal[pal1 ? PAL_OBP1 : PAL_OBP0] >> {obj, 1'b0});
		end
		return shade_t'(model_pal[PAL_BGP] >> {bg, 1'b0});
	endfunction

	// galois lfsr stepped once for every bit taken.
	function automatic logic [7:0] lfsr_bits(input int n);
		logic [7:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[6:0], lfsr[0]};
			lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
		end
		return bits;
	endfunction

	// shade scoreboard on the falling edge.
	always @(negedge clk) begin
		if (reset === 1'b0) begin
			if (shade_valid !== valid_hist[1]) begin
				$display("shade_valid is %b, two cycles after a pix_valid of %b",
					shade_valid, valid_hist[1]);
				other_errors++;
			end
			if (shade_valid && exp_q.size() != 0) begin
				check_shade("shade", shade, exp_q.pop_front());
			end
			if (pix_valid) begin
				exp_q.push_back(model_shade(bg_color, obj_color, obj_pal1, obj_behind_bg));
			end
			valid_hist = {valid_hist[0], pix_valid};
		end
	end

	task automatic write_reg(input logic [1:0] reg_idx, input cpu_data_t data);
		@(posedge clk);
		cpu_addr <= BASE + addr_t'(reg_idx);
		cpu_wdata <= data;
		cpu_wr2 <= 1'b1;
		@(posedge clk);
		cpu_wr2 <= 1'b0;
		model_pal[reg_idx] = data;
	endtask

	// read data is due one cycle after the strobe.
	task automatic read_check(input logic [1:0] reg_idx, input cpu_data_t exp);
		int waited;
		@(posedge clk);
		cpu_addr <= BASE + addr_t'(reg_idx);
		cpu_rd2 <= 1'b1;
		@(posedge clk);
		cpu_rd2 <= 1'b0;
		@(negedge clk);
		for (waited = 0; !cpu_rdata_valid && waited < TIMEOUT; waited++) begin
			@(negedge clk);
		end
		if (waited != 0) begin
			$display("cpu_rdata_valid late or missing for register %0d", reg_idx);
			other_errors++;
		end
		check_data("cpu_rdata", cpu_rdata, exp);
		@(negedge clk);
		if (cpu_rdata_valid) begin
			$display("cpu_rdata_valid stayed high for more than one cycle");
			other_errors++;
		end
	endtask

	task automatic drive_pixel(input color_idx_t bg, input color_idx_t obj, input logic pal1,
			input logic behind);
		@(posedge clk);
		pix_valid <= 1'b1;
		bg_color <= bg;
		obj_color <= obj;
		obj_pal1 <= pal1;
		obj_behind_bg <= behind;
	endtask

	task automatic drain_pixels();
		int waited;
		@(posedge clk);
		pix_valid <= 1'b0;
		for (waited = 0; exp_q.size() != 0 && waited < TIMEOUT; waited++) begin
			@(negedge clk);
		end
		if (exp_q.size() != 0) begin
			$display("pipe did not drain, %0d shades never came out", exp_q.size());
			other_errors++;
		end
	endtask

	task automatic reset_values();
		read_check(2'd0, 8'h00);
		read_check(2'd1, 8'h00);
		read_check(2'd2, 8'h00);
		read_check(2'd3, UNMAPPED_READ);
	endtask

	task automatic register_readback();
		write_reg(2'd0, 8'ha5);
		write_reg(2'd1, 8'h3c);
		write_reg(2'd2, 8'h96);
		read_check(2'd0, 8'ha5);
		read_check(2'd1, 8'h3c);
		read_check(2'd2, 8'h96);
		// obp0 rewritten alone.
		write_reg(2'd1, 8'h5a);
		read_check(2'd0, 8'ha5);
		read_check(2'd1, 8'h5a);
		read_check(2'd2, 8'h96);
		// bgp rewritten alone.
		write_reg(2'd0, 8'h69);
		read_check(2'd0, 8'h69);
		read_check(2'd1, 8'h5a);
		read_check(2'd2, 8'h96);
	endtask

	task automatic background_shades();
		write_reg(2'd0, 8'he4);
		for (int i = 0; i < 4; i++) begin
			drive_pixel(color_idx_t'(i), 2'd0, 1'b0, 1'b0);
		end
		drain_pixels();
		write_reg(2'd0, 8'h1b);
		for (int i = 0; i < 4; i++) begin
			drive_pixel(color_idx_t'(i), 2'd0, 1'b0, 1'b0);
		end
		drain_pixels();
	endtask

	// the three palettes give three different shades for any color index.
	task automatic sprite_priority();
		write_reg(2'd0, 8'he4);
		write_reg(2'd1, 8'h1b);
		write_reg(2'd2, 8'h4e);
		for (int i = 0; i < 64; i++) begin
			drive_pixel(color_idx_t'(i >> 4), color_idx_t'(i >> 2), i[1], i[0]);
		end
		drain_pixels();
	endtask

	task automatic random_pixel_stream();
		logic [7:0] r;
		write_reg(2'd0, lfsr_bits(8));
		write_reg(2'd1, lfsr_bits(8));
		write_reg(2'd2, lfsr_bits(8));
		for (int n = 0; n < 200; n++) begin
			r = lfsr_bits(6);
			drive_pixel(r[5:4], r[3:2], r[1], r[0]);
		end
		drain_pixels();
	endtask

	initial begin
		reset <= 1'b1;
		cpu_addr <= '0;
		cpu_wdata <= '0;
		cpu_rd2 <= 1'b0;
		cpu_wr2 <= 1'b0;
		pix_valid <= 1'b0;
		bg_color <= '0;
		obj_color <= '0;
		obj_pal1 <= 1'b0;
		obj_behind_bg <= 1'b0;
		repeat (16) begin
			@(posedge clk);
		end
		reset <= 1'b0;
		reset_values();
		register_readback();
		background_shades();
		sprite_priority();
		random_pixel_stream();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/cpu_io_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_io_decode
	import ppu_pkg::*;
	#(
		parameter addr_t PAL_BASE = ADDR_BGP_DEFAULT
	)
	(
		input  logic      clk,
		input  logic      reset,

		input  addr_t     cpu_addr,
		input  logic      cpu_rd2,
		input  logic      cpu_wr2,

		// combinational read data from the palette block.
		input  cpu_data_t rd_data,

		output logic      ff47,
		output logic      ff48,
		output logic      ff49,
		output logic      wr_en,

		output cpu_data_t cpu_rdata,
		output logic      cpu_rdata_valid
	);

	localparam addr_t ADDR_BGP  = PAL_BASE;
	localparam addr_t ADDR_OBP0 = addr_t'(PAL_BASE + 16'd1);
	localparam addr_t ADDR_OBP1 = addr_t'(PAL_BASE + 16'd2);

	logic pal_hit;

	// one select at most, the addresses differ.
	assign ff47 = (cpu_addr == ADDR_BGP);
	assign ff48 = (cpu_addr == ADDR_OBP0);
	assign ff49 = (cpu_addr == ADDR_OBP1);

	assign pal_hit = ff47 | ff48 | ff49;

	// writes to unmapped addresses never reach the palettes.
	assign wr_en = cpu_wr2 & pal_hit;

	always_ff @(posedge clk) begin
		if (reset) begin
			cpu_rdata_valid <= 1'b0;
		end else begin
			cpu_rdata_valid <= cpu_rd2;
		end
	end

	// read return register, holds until the next read.
	always_ff @(posedge clk) begin
		if (cpu_rd2) begin
			cpu_rdata <= pal_hit ? rd_data : UNMAPPED_READ;
		end
	end

endmodule

`default_nettype wire

// File: verilog/lcd_palette_top.sv
`timescale 1ns/1ps
`default_nettype none

module lcd_palette_top
	import ppu_pkg::*;
	#(
		parameter addr_t PAL_BASE = ADDR_BGP_DEFAULT
	)
	(
		input  logic       clk,
		input  logic       reset,

		// cpu port.
		input  addr_t      cpu_addr,
		input  cpu_data_t  cpu_wdata,
		input  logic       cpu_rd2,
		input  logic       cpu_wr2,
		output cpu_data_t  cpu_rdata,
		output logic       cpu_rdata_valid,

		// pixel stream in.
		input  logic       pix_valid,
		input  color_idx_t bg_color,
		input  color_idx_t obj_color,
		input  logic       obj_pal1,
		input  logic       obj_behind_bg,

		// shade out, two cycles after the pixel.
		output logic       shade_valid,
		output shade_t     shade
	);

	logic       ff47;
	logic       ff48;
	logic       ff49;
	logic       wr_en;
	cpu_data_t  rd_data;

	palette_t   bgp_d;
	palette_t   obp0_d;
	palette_t   obp1_d;

	logic       mix_valid;
	color_idx_t mix_color;
	pal_sel_t   mix_pal;

	cpu_io_decode #(
		.PAL_BASE(PAL_BASE)
	) u_cpu_io_decode (
		.clk            (clk),
		.reset          (reset),
		.cpu_addr       (cpu_addr),
		.cpu_rd2        (cpu_rd2),
		.cpu_wr2        (cpu_wr2),
		.rd_data        (rd_data),
		.ff47           (ff47),
		.ff48           (ff48),
		.ff49           (ff49),
		.wr_en          (wr_en),
		.cpu_rdata      (cpu_rdata),
		.cpu_rdata_valid(cpu_rdata_valid)
	);

	palettes u_palettes (
		.clk    (clk),
		.reset  (reset),
		.wr_en  (wr_en),
		.ff47   (ff47),
		.ff48   (ff48),
		.ff49   (ff49),
		.wdata  (cpu_wdata),
		.rd_data(rd_data),
		.bgp_d  (bgp_d),
		.obp0_d (obp0_d),
		.obp1_d (obp1_d)
	);

	pixel_mixer u_pixel_mixer (
		.clk          (clk),
		.reset        (reset),
		.pix_valid    (pix_valid),
		.bg_color     (bg_color),
		.obj_color    (obj_color),
		.obj_pal1     (obj_pal1),
		.obj_behind_bg(obj_behind_bg),
		.mix_valid    (mix_valid),
		.mix_color    (mix_color),
		.mix_pal      (mix_pal)
	);

	shade_lookup u_shade_lookup (
		.clk        (clk),
		.reset      (reset),
		.mix_valid  (mix_valid),
		.mix_color  (mix_color),
		.mix_pal    (mix_pal),
		.bgp_d      (bgp_d),
		.obp0_d     (obp0_d),
		.obp1_d     (obp1_d),
		.shade_valid(shade_valid),
		.shade      (shade)
	);

endmodule

`default_nettype wire

// File: verilog/palettes.sv
`timescale 1ns/1ps
`default_nettype none

module palettes
	import ppu_pkg::*;
	(
		input  logic      clk,
		input  logic      reset,

		input  logic      wr_en,
		input  logic      ff47,
		input  logic      ff48,
		input  logic      ff49,
		input  cpu_data_t wdata,

		output cpu_data_t rd_data,

		output palette_t  bgp_d,
		output palette_t  obp0_d,
		output palette_t  obp1_d
	);

	localparam int NUM_PAL = 3;

	// one entry per register, ordered bgp, obp0, obp1.
	palette_t          pal_q [NUM_PAL];
	logic [NUM_PAL-1:0] sel;

	assign sel = {ff49, ff48, ff47};

	// flip-flops where the console has transparent latches.
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_PAL; i++) begin
				pal_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_PAL; i++) begin
				if (wr_en && sel[i]) begin
					pal_q[i] <= palette_t'(wdata);
				end
			end
		end
	end

	// read mux, zero when nothing is addressed.
	always_comb begin
		rd_data = '0;
		for (int i = 0; i < NUM_PAL; i++) begin
			if (sel[i]) begin
				rd_data = cpu_data_t'(pal_q[i]);
			end
		end
	end

	// live register values to the pixel path.
	assign bgp_d  = pal_q[PAL_BGP];
	assign obp0_d = pal_q[PAL_OBP0];
	assign obp1_d = pal_q[PAL_OBP1];

endmodule

`default_nettype wire

// File: verilog/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer
	import ppu_pkg::*;
	(
		input  logic       clk,
		input  logic       reset,

		input  logic       pix_valid,
		input  color_idx_t bg_color,
		input  color_idx_t obj_color,
		input  logic       obj_pal1,
		input  logic       obj_behind_bg,

		output logic       mix_valid,
		output color_idx_t mix_color,
		output pal_sel_t   mix_pal
	);

	logic       bg_opaque;
	logic       obj_opaque;
	logic       obj_wins;
	color_idx_t sel_color;
	pal_sel_t   sel_pal;

	// color 0 is transparent for sprites.
	assign bg_opaque  = (bg_color != '0);
	assign obj_opaque = (obj_color != '0);

	// a sprite behind the background only shows through color 0.
	assign obj_wins = obj_opaque && (!obj_behind_bg || !bg_opaque);

	always_comb begin
		if (obj_wins) begin
			sel_color = obj_color;
			sel_pal   = obj_pal1 ? PAL_OBP1 : PAL_OBP0;
		end else begin
			sel_color = bg_color;
			sel_pal   = PAL_BGP;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mix_valid <= 1'b0;
		end else begin
			mix_valid <= pix_valid;
		end
	end

	// pixel payload, only loaded with a valid pixel.
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			mix_color <= sel_color;
			mix_pal   <= sel_pal;
		end
	end

endmodule

`default_nettype wire

// File: verilog/ppu_pkg.sv
package ppu_pkg;

	// cpu bus.
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  cpu_data_t;

	// palette register, two bits of shade per color index.
	// bits 1:0 give the shade of color 0, bits 7:6 that of color 3.
	typedef logic [7:0] palette_t;

	// pixel side.
	typedef logic [1:0] color_idx_t;
	typedef logic [1:0] shade_t;
	typedef logic [1:0] pal_sel_t;

	// which palette a mixed pixel is looked up in.
	localparam pal_sel_t PAL_BGP  = 2'd0;
	localparam pal_sel_t PAL_OBP0 = 2'd1;
	localparam pal_sel_t PAL_OBP1 = 2'd2;

	// bgp sits here on the real console, obp0 and obp1 follow it.
	localparam addr_t ADDR_BGP_DEFAULT = 16'hff47;

	// data returned for a read that hits no palette.
	localparam cpu_data_t UNMAPPED_READ = 8'hff;

endpackage

// File: verilog/shade_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module shade_lookup
	import ppu_pkg::*;
	(
		input  logic       clk,
		input  logic       reset,

		input  logic       mix_valid,
		input  color_idx_t mix_color,
		input  pal_sel_t   mix_pal,

		input  palette_t   bgp_d,
		input  palette_t   obp0_d,
		input  palette_t   obp1_d,

		output logic       shade_valid,
		output shade_t     shade
	);

	palette_t pal;
	shade_t   next_shade;

	// the palette is sampled at this stage's edge, not at stage 1.
	always_comb begin
		case (mix_pal)
			PAL_OBP0: pal = obp0_d;
			PAL_OBP1: pal = obp1_d;
			default:  pal = bgp_d;
		endcase
	end

	// two bits per color index, color 0 in the low bits.
	assign next_shade = shade_t'(pal[{mix_color, 1'b0} +: 2]);

	always_ff @(posedge clk) begin
		if (reset) begin
			shade_valid <= 1'b0;
		end else begin
			shade_valid <= mix_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (mix_valid) begin
			shade <= next_shade;
		end
	end

endmodule

`default_nettype wire
